// File: hw/readout_pkg.sv
package readout_pkg;

  ////////////////////////////////////////
  // word and burst widths

  localparam int WORD_WIDTH      = 32;                       // one transmit word
  localparam int BURST_WIDTH     = 128;                      // one memory burst
  localparam int WORDS_PER_BURST = BURST_WIDTH / WORD_WIDTH; // 4 words per burst
  localparam int WORD_IDX_W      = $clog2(WORDS_PER_BURST);  // word index inside a burst

  typedef logic [WORD_WIDTH-1:0]  word_t;
  typedef logic [BURST_WIDTH-1:0] burst_t;

  ////////////////////////////////////////
  // beats carried through the FIFOs

  typedef struct packed {
    logic  last;  // end of command packet
    word_t data;
  } cmd_beat_t;   // 33 bits

  typedef struct packed {
    logic   last; // final burst of the readout
    burst_t data;
  } burst_beat_t; // 129 bits

  localparam int CMD_FIFO_DEPTH   = 8;  // command words in flight
  localparam int BURST_FIFO_DEPTH = 8;  // memory bursts in flight

endpackage

// File: hw/control_pkg.sv
package control_pkg;

  ////////////////////////////////////////
  // synchronizers

  localparam int SYNC_STAGES = 2;  // flops on every asynchronous level from the master

  ////////////////////////////////////////
  // master reset classification

  localparam int LONG_HOLD_CYCLES  = 32;  // synced-high cycles that make an assertion long
  localparam int LONG_RESET_CYCLES = 16;  // full reset stretch after release

  localparam int HOLD_CNT_W    = $clog2(LONG_HOLD_CYCLES + 1);   // saturating hold counter
  localparam int STRETCH_CNT_W = $clog2(LONG_RESET_CYCLES + 1);  // stretch down-counter

  typedef logic [HOLD_CNT_W-1:0]    hold_cnt_t;
  typedef logic [STRETCH_CNT_W-1:0] stretch_cnt_t;

endpackage

// File: hw/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
  parameter type payload_t = logic,  // whole beat, data plus flags
  parameter int  DEPTH     = 8       // entries
) (
  input  logic     clk125,
  input  logic     reset,
  input  payload_t in_beat,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_beat,
  output logic     out_valid,
  input  logic     out_ready
);

  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  payload_t mem [DEPTH];  // storage, no reset
  ptr_t     wr_ptr;       // next slot to write
  ptr_t     rd_ptr;       // head of queue
  cnt_t     count;        // occupancy
  logic     wr_en;
  logic     rd_en;

  function automatic ptr_t ptr_inc(input ptr_t p);
    return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;  // wrap for any depth
  endfunction

  assign in_ready  = (count != cnt_t'(DEPTH));  // low only when full
  assign out_valid = (count != '0);
  assign out_beat  = mem[rd_ptr];               // head is visible the cycle after its write
  assign wr_en     = in_valid && in_ready;
  assign rd_en     = out_valid && out_ready;

  always_ff @(posedge clk125) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_beat;
    end
  end

  always_ff @(posedge clk125) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;  // out_valid low after reset
    end else begin
      if (wr_en) wr_ptr <= ptr_inc(wr_ptr);
      if (rd_en) rd_ptr <= ptr_inc(rd_ptr);
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle or push and pop together
      endcase
    end
  end

endmodule

// File: hw/burst_width_converter.sv
`timescale 1ns/1ps

module burst_width_converter
  import readout_pkg::*;
(
  input  logic        clk125,
  input  logic        reset,
  input  burst_beat_t burst_in,
  input  logic        burst_valid,
  output logic        burst_ready,
  output word_t       word_data,
  output logic        word_last,
  output logic        word_valid,
  input  logic        word_ready
);

  burst_t                burst_q;     // burst being sent
  logic                  last_q;      // its end-of-readout flag
  logic                  full;        // holding a burst
  logic [WORD_IDX_W-1:0] idx;         // current word, lowest first
  logic                  final_word;  // idx points at word 3
  logic                  word_acc;
  logic                  load;

  assign final_word = (idx == WORD_IDX_W'(WORDS_PER_BURST - 1));
  assign word_acc   = word_valid && word_ready;

  // refill on the edge that takes word 3 so the output has no gap
  assign burst_ready = !full || (word_acc && final_word);
  assign load        = burst_valid && burst_ready;

  assign word_valid = full;
  assign word_data  = burst_q[idx*WORD_WIDTH +: WORD_WIDTH];
  assign word_last  = last_q && final_word;  // only the last word of a flagged burst

  always_ff @(posedge clk125) begin
    if (load) begin
      burst_q <= burst_in.data;
      last_q  <= burst_in.last;
    end
  end

  always_ff @(posedge clk125) begin
    if (reset) begin
      full <= 1'b0;
      idx  <= '0;
    end else if (load) begin
      full <= 1'b1;
      idx  <= '0;                    // start again at the low word
    end else if (word_acc) begin
      if (final_word) full <= 1'b0;  // drained, nothing waiting
      idx <= final_word ? '0 : idx + 1'b1;
    end
  end

endmodule

// File: hw/tx_source_arbiter.sv
`timescale 1ns/1ps

module tx_source_arbiter
  import readout_pkg::*, control_pkg::*;
(
  input  logic      clk125,
  input  logic      reset,
  input  logic      readout_pause,
  input  logic      read_start,
  input  cmd_beat_t cmd_beat,
  input  logic      cmd_valid,
  output logic      cmd_ready,
  input  word_t     mem_data,
  input  logic      mem_last,
  input  logic      mem_valid,
  output logic      mem_ready,
  output word_t     tx_data,
  output logic      tx_last,
  output logic      tx_valid,
  input  logic      tx_ready,
  output logic      readout_active
);

  logic [SYNC_STAGES-1:0] pause_sync;     // pause level from the master
  logic                   paused;
  logic                   pkt_open;       // command packet in progress
  logic                   pkt_open_next;
  logic                   read_pending;   // read request waiting for a packet boundary
  logic                   read_req;
  logic                   cmd_acc;
  logic                   mem_acc;

  assign paused = pause_sync[SYNC_STAGES-1];

  ////////////////////////////////////////
  // 2:1 stream mux

  assign tx_data  = readout_active ? mem_data : cmd_beat.data;
  assign tx_last  = readout_active ? mem_last : cmd_beat.last;
  assign tx_valid = !paused && (readout_active ? mem_valid : cmd_valid);  // held off while paused

  // only the selected source sees ready
  assign mem_ready = readout_active && tx_ready && !paused;
  assign cmd_ready = !readout_active && tx_ready && !paused;

  assign cmd_acc = cmd_valid && cmd_ready;
  assign mem_acc = mem_valid && mem_ready;

  ////////////////////////////////////////
  // source select

  assign pkt_open_next = cmd_acc ? !cmd_beat.last : pkt_open;  // boundary after a last beat
  assign read_req      = read_pending || read_start;

  always_ff @(posedge clk125) begin
    if (reset) begin
      pause_sync     <= '0;
      pkt_open       <= 1'b0;  // between packets after reset
      read_pending   <= 1'b0;
      readout_active <= 1'b0;
    end else begin
      pause_sync <= {pause_sync[SYNC_STAGES-2:0], readout_pause};
      pkt_open   <= pkt_open_next;
      if (!readout_active && read_req && !pkt_open_next) begin
        readout_active <= 1'b1;  // switch to memory on the boundary
        read_pending   <= 1'b0;
      end else begin
        if (mem_acc && mem_last) begin
          readout_active <= 1'b0;  // back to commands after the final word
        end
        if (read_start) begin
          read_pending <= 1'b1;    // hold until the packet finishes
        end
      end
    end
  end

endmodule

// File: hw/master_reset.sv
`timescale 1ns/1ps

module master_reset
  import control_pkg::*;
(
  input  logic clk125,
  input  logic reset,
  input  logic rst_from_master,
  output logic counter_reset,
  output logic long_reset
);

  logic [SYNC_STAGES-1:0] sync;         // master reset level, synchronized
  logic                   level;
  logic                   level_q;      // previous synced level, for the falling edge
  logic                   fall;
  logic                   hold_full;    // assertion already counts as long
  hold_cnt_t              hold_cnt;     // synced-high cycles, saturating
  stretch_cnt_t           stretch_cnt;  // cycles of full reset left after release

  assign level     = sync[SYNC_STAGES-1];
  assign fall      = level_q && !level;
  assign hold_full = (hold_cnt == hold_cnt_t'(LONG_HOLD_CYCLES));

  always_ff @(posedge clk125) begin
    if (reset) begin
      sync          <= '0;
      level_q       <= 1'b0;
      hold_cnt      <= '0;
      stretch_cnt   <= '0;
      counter_reset <= 1'b0;
      long_reset    <= 1'b0;
    end else begin
      sync    <= {sync[SYNC_STAGES-2:0], rst_from_master};
      level_q <= level;

      // short assertion ends here, one pulse
      counter_reset <= fall && !hold_full && !long_reset;

      if (!level) begin
        hold_cnt <= '0;
      end else if (!hold_full) begin
        hold_cnt <= hold_cnt + 1'b1;
      end

      ////////////////////////////////////////
      // long assertion and its stretch
      if (level && hold_cnt >= hold_cnt_t'(LONG_HOLD_CYCLES - 1)) begin  // count reaches limit
        long_reset  <= 1'b1;
        stretch_cnt <= stretch_cnt_t'(LONG_RESET_CYCLES);  // reload while held
      end else if (long_reset && !level) begin
        if (stretch_cnt == stretch_cnt_t'(1)) long_reset <= 1'b0;
        stretch_cnt <= stretch_cnt - 1'b1;
      end
    end
  end

endmodule

// File: hw/channel_readout_top.sv
`timescale 1ns/1ps

module channel_readout_top
  import readout_pkg::*;
(
  input  logic   clk125,
  input  logic   reset,
  input  logic   rst_from_master,  // level from the master FPGA
  input  logic   readout_pause,    // level from the master FPGA
  input  logic   read_start,       // strobe, start a memory readout
  input  word_t  cmd_data,
  input  logic   cmd_last,
  input  logic   cmd_valid,
  output logic   cmd_ready,
  input  burst_t burst_data,
  input  logic   burst_last,
  input  logic   burst_valid,
  output logic   burst_ready,
  output word_t  tx_data,
  output logic   tx_last,
  output logic   tx_valid,
  input  logic   tx_ready,
  output logic   readout_active,
  output logic   counter_reset,
  output logic   long_reset
);

  logic        core_reset;      // long master reset flushes the readout path
  cmd_beat_t   cmd_in_beat;
  cmd_beat_t   cmd_q_beat;      // command FIFO head
  logic        cmd_q_valid, cmd_q_ready;
  burst_beat_t burst_in_beat;
  burst_beat_t burst_q_beat;    // burst FIFO head
  logic        burst_q_valid, burst_q_ready;
  word_t       mem_data;        // converter output
  logic        mem_last, mem_valid, mem_ready;

  assign core_reset = reset || long_reset;

  assign cmd_in_beat.data   = cmd_data;
  assign cmd_in_beat.last   = cmd_last;
  assign burst_in_beat.data = burst_data;
  assign burst_in_beat.last = burst_last;

  master_reset u_master_reset (.clk125, .reset, .rst_from_master, .counter_reset, .long_reset);

  stream_fifo #(.payload_t(cmd_beat_t), .DEPTH(CMD_FIFO_DEPTH)) cmd_fifo (
    .clk125, .reset(core_reset), .in_beat(cmd_in_beat), .in_valid(cmd_valid),
    .in_ready(cmd_ready), .out_beat(cmd_q_beat), .out_valid(cmd_q_valid),
    .out_ready(cmd_q_ready));

  stream_fifo #(.payload_t(burst_beat_t), .DEPTH(BURST_FIFO_DEPTH)) burst_fifo (
    .clk125, .reset(core_reset), .in_beat(burst_in_beat), .in_valid(burst_valid),
    .in_ready(burst_ready), .out_beat(burst_q_beat), .out_valid(burst_q_valid),
    .out_ready(burst_q_ready));

  burst_width_converter u_converter (
    .clk125, .reset(core_reset), .burst_in(burst_q_beat), .burst_valid(burst_q_valid),
    .burst_ready(burst_q_ready), .word_data(mem_data), .word_last(mem_last),
    .word_valid(mem_valid), .word_ready(mem_ready));

  tx_source_arbiter u_arbiter (
    .clk125, .reset(core_reset), .readout_pause, .read_start,
    .cmd_beat(cmd_q_beat), .cmd_valid(cmd_q_valid), .cmd_ready(cmd_q_ready),
    .mem_data, .mem_last, .mem_valid, .mem_ready,
    .tx_data, .tx_last, .tx_valid, .tx_ready, .readout_active);

endmodule

// File: bench/channel_readout_tb.sv
`timescale 1ns/1ps

module channel_readout_tb
  import readout_pkg::*, control_pkg::*;
();

  localparam int TEST_CYCLES    = 1500;                   // rough length of all tests
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 1000; // margin over the test length

  logic   clk125 = 1'b0;
  logic   reset, rst_from_master, readout_pause, read_start;
  word_t  cmd_data;
  logic   cmd_last, cmd_valid, cmd_ready;
  burst_t burst_data;
  logic   burst_last, burst_valid, burst_ready;
  word_t  tx_data;
  logic   tx_last, tx_valid;
  logic   tx_ready = 1'b0;                    // driven by the back-pressure process
  logic   readout_active, counter_reset, long_reset;

  logic [31:0] data_state = 32'd28;            // xorshift state for data values
  logic [31:0] bp_state   = 32'd28;            // xorshift state for tx_ready
  logic        bp_hold    = 1'b0;              // forces tx_ready low
  logic [33:0] scoreboard[$];                  // {is_mem, last, data} in tx order
  burst_t      pending_bursts[$];              // loaded but not yet expected
  int          errors = 0;
  int          checks = 0;
  int          cycle_count = 0;
  int          pause_cycles = 0;
  logic        mem_end_seen = 1'b0;
  logic        long_reset_q = 1'b0;

  always #2 clk125 = ~clk125;  // 4 ns period

  channel_readout_top DUT (.*);

  ////////////////////////////////////////
  // reference model and checking

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_word();
    data_state = xorshift32(data_state);
    return data_state;
  endfunction

  // word 0 comes from the low bits of the burst
  function automatic word_t expected_word(input burst_t burst, input int idx);
    burst_t shifted;
    shifted = burst >> (WORD_WIDTH * idx);
    return shifted[WORD_WIDTH-1:0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("[ERROR] %0t %s", $time, msg);
  endtask

  ////////////////////////////////////////
  // stimulus helpers, all return at rising edge + 0.5 ns

  task automatic step_cycle();
    @(posedge clk125);
    #0.5;
  endtask

  task automatic push_cmd(input word_t d, input logic l);
    cmd_data  = d;
    cmd_last  = l;
    cmd_valid = 1'b1;
    @(negedge clk125);
    while (!cmd_ready) @(negedge clk125);  // taken on the next rising edge
    step_cycle();
    cmd_valid = 1'b0;
    scoreboard.push_back({1'b0, l, d});
  endtask

  task automatic send_packet(input int len);
    for (int i = 0; i < len; i++) push_cmd(rand_word(), i == len - 1);
  endtask

  task automatic load_bursts(input int n);
    burst_t b;
    for (int i = 0; i < n; i++) begin
      b = {rand_word(), rand_word(), rand_word(), rand_word()};
      burst_data  = b;
      burst_last  = (i == n - 1);  // final burst ends the readout
      burst_valid = 1'b1;
      @(negedge clk125);
      while (!burst_ready) @(negedge clk125);
      step_cycle();
      burst_valid = 1'b0;
      pending_bursts.push_back(b);
    end
  endtask

  task automatic expect_pending();
    burst_t b;
    while (pending_bursts.size() != 0) begin
      b = pending_bursts.pop_front();
      for (int i = 0; i < WORDS_PER_BURST; i++) begin
        scoreboard.push_back({1'b1, (pending_bursts.size() == 0) && (i == WORDS_PER_BURST - 1),
                              expected_word(b, i)});
      end
    end
  endtask

  task automatic pulse_read_start();
    read_start = 1'b1;
    step_cycle();
    read_start = 1'b0;
  endtask

  task automatic wait_drain();
    while (scoreboard.size() != 0) step_cycle();
    repeat (3) step_cycle();
  endtask

  task automatic track_master_reset(input int cycles, input int pulse_at);
    for (int i = 1; i <= cycles; i++) begin
      @(negedge clk125);
      check_value("counter_reset", 32'(counter_reset), 32'(i == pulse_at));
      check_value("long_reset", 32'(long_reset), 32'd0);
    end
    step_cycle();
  endtask

  ////////////////////////////////////////
  // monitors, sampled mid cycle

  always @(posedge clk125) begin
    logic hold_now;
    hold_now = bp_hold;  // sampled at the edge, acts from this cycle
    #0.5;
    bp_state = xorshift32(bp_state);
    tx_ready = !hold_now && (bp_state[0] || bp_state[1]);  // ready about 3 cycles in 4
  end

  always @(negedge clk125) begin
    logic [33:0] exp_beat;
    if (long_reset && !long_reset_q) scoreboard.delete();  // flushed words never appear
    long_reset_q = long_reset;
    if (mem_end_seen) check_value("readout_active", 32'(readout_active), 32'd0);
    mem_end_seen = 1'b0;
    if (!reset && tx_valid && tx_ready) begin
      if (scoreboard.size() == 0) begin
        report_error($sformatf("tx word %h accepted while nothing was expected", tx_data));
      end else begin
        exp_beat = scoreboard.pop_front();
        check_value("tx_data", tx_data, exp_beat[31:0]);
        check_value("tx_last", 32'(tx_last), 32'(exp_beat[32]));
        check_value("readout_active", 32'(readout_active), 32'(exp_beat[33]));
        mem_end_seen = exp_beat[33] && exp_beat[32];  // falls on the next edge
      end
    end
  end

  always @(negedge clk125) begin
    pause_cycles = readout_pause ? pause_cycles + 1 : 0;
    if (pause_cycles >= 3) check_value("tx_valid", 32'(tx_valid), 32'd0);  // synced pause
  end

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk125);
      cycle_count++;
    end
    $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////
  // test sequence

  initial begin
    int stretch;
    logic long_seen;
    reset           = 1'b1;
    rst_from_master = 1'b0;
    readout_pause   = 1'b0;
    read_start      = 1'b0;
    cmd_data        = '0;
    cmd_last        = 1'b0;
    cmd_valid       = 1'b0;
    burst_data      = '0;
    burst_last      = 1'b0;
    burst_valid     = 1'b0;
    repeat (16) @(posedge clk125);
    #0.5;
    reset = 1'b0;
    step_cycle();

    for (int p = 0; p < 40; p++) send_packet(int'(rand_word() % 32'd6) + 1);  // passthrough
    wait_drain();

    for (int r = 0; r < 4; r++) begin  // plain readouts
      load_bursts(5);
      expect_pending();
      pulse_read_start();
      wait_drain();
    end

    load_bursts(3);                  // read request inside a command packet
    push_cmd(rand_word(), 1'b0);
    push_cmd(rand_word(), 1'b0);
    wait_drain();                    // packet now open at the arbiter
    pulse_read_start();
    repeat (5) step_cycle();         // request must stay pending
    push_cmd(rand_word(), 1'b0);
    push_cmd(rand_word(), 1'b1);
    expect_pending();
    send_packet(4);                  // follows the readout
    wait_drain();

    send_packet(3);                  // pause on the command path
    readout_pause = 1'b1;
    send_packet(4);
    repeat (20) step_cycle();
    readout_pause = 1'b0;
    wait_drain();
    load_bursts(2);                  // pause during a readout
    expect_pending();
    pulse_read_start();
    repeat (3) step_cycle();
    readout_pause = 1'b1;
    repeat (20) step_cycle();
    readout_pause = 1'b0;
    wait_drain();

    rst_from_master = 1'b1;          // short master reset
    track_master_reset(5, 0);
    rst_from_master = 1'b0;
    track_master_reset(10, 4);       // first look is in the cycle of the fall

    load_bursts(2);                  // long master reset flushes a stalled readout
    expect_pending();
    bp_hold = 1'b1;
    step_cycle();
    pulse_read_start();
    repeat (4) step_cycle();
    rst_from_master = 1'b1;
    long_seen = 1'b0;
    repeat (60) begin
      @(negedge clk125);
      check_value("counter_reset", 32'(counter_reset), 32'd0);
      if (long_reset) long_seen = 1'b1;
      step_cycle();
    end
    if (!long_seen) report_error("long_reset did not rise during a 60 cycle master reset");
    rst_from_master = 1'b0;
    stretch = 0;
    repeat (40) begin
      @(negedge clk125);
      check_value("counter_reset", 32'(counter_reset), 32'd0);
      if (long_reset) stretch++;
      step_cycle();
    end
    // synced level drops SYNC_STAGES cycles late, then the stretch runs
    check_value("long_reset stretch", 32'(stretch), 32'(SYNC_STAGES + LONG_RESET_CYCLES));
    bp_hold = 1'b0;
    repeat (20) step_cycle();
    check_value("readout_active", 32'(readout_active), 32'd0);  // flushed readout ends
    send_packet(5);                  // traffic after the stretch
    load_bursts(3);
    expect_pending();
    pulse_read_start();
    wait_drain();

    $display("summary: %0d checks, %0d errors, %0d cycles", checks, errors, cycle_count);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: sources.f
hw/readout_pkg.sv
hw/control_pkg.sv
hw/stream_fifo.sv
hw/burst_width_converter.sv
hw/tx_source_arbiter.sv
hw/master_reset.sv
hw/channel_readout_top.sv
bench/channel_readout_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the channel readout testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
  -f sources.f \
  --top-module channel_readout_tb \
  -o channel_readout_sim

./obj_dir/channel_readout_sim | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
  echo "run_sim: failure reported in $LOG"
  exit 1
fi

echo "run_sim: no failure reported"
exit 0
